// ==== issue_decoder.f ====
+incdir+.
issue_pkg.sv
issue_if.sv
issue_opcode_classify.sv
issue_funct_decode.sv
issue_decode_merge.sv
issue_decoder_top.sv
tb_issue_decoder.sv

// ==== Bender.yml ====
package:
  name: issue_decoder

sources:
  - files:
      - issue_pkg.sv
      - issue_if.sv
      - issue_opcode_classify.sv
      - issue_funct_decode.sv
      - issue_decode_merge.sv
      - issue_decoder_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_issue_decoder.sv

// ==== tb_issue_vectors.svh ====
/*
 * Issue decoder test table
 * Instruction templates with their expected registered results
 */

// Columns: name, instruction word, random fields {rd, rs1, rs2},
// unit, unit control, {rs1_req, rs1_is_pc, rs2_req, rs2_is_imm, regstat_upd},
// immediate format, {res_ready, stall_possible}, exception code or 0
localparam int NUM_VEC = 26;

vec_t vectors [NUM_VEC] = '{
    // Arithmetic and logic
    '{"add", 32'h002081B3, 7, EU_INT_ALU, 8'(ALU_ADD), 5'b10101, IMM_TYPE_I, 2'b00, 0},
    '{"subw", 32'h407302BB, 7, EU_INT_ALU, 8'(ALU_SUBW), 5'b10101, IMM_TYPE_I, 2'b00, 0},
    '{"addi", 32'h00510093, 6, EU_INT_ALU, 8'(ALU_ADD), 5'b10011, IMM_TYPE_I, 2'b00, 0},
    '{"srai", 32'h4212D213, 7, EU_INT_ALU, 8'(ALU_SRA), 5'b10011, IMM_TYPE_I, 2'b00, 0},
    '{"sltiu", 32'hFFF3B313, 6, EU_INT_ALU, 8'(ALU_SLTU), 5'b10011, IMM_TYPE_I, 2'b00, 0},
    '{"slliw", 32'h0034941B, 7, EU_INT_ALU, 8'(ALU_SLLW), 5'b10011, IMM_TYPE_I, 2'b00, 0},
    // Memory, branch and jumps
    '{"lhu", 32'h0085D503, 6, EU_LOAD_BUFFER, 8'(LS_HALFWORD_U), 5'b10001, IMM_TYPE_I, 2'b00, 0},
    '{"ld", 32'h0106B603, 6, EU_LOAD_BUFFER, 8'(LS_DOUBLEWORD), 5'b10001, IMM_TYPE_I, 2'b00, 0},
    '{"sb", 32'h00E78223, 7, EU_STORE_BUFFER, 8'(LS_BYTE), 5'b10100, IMM_TYPE_S, 2'b00, 0},
    '{"sd", 32'h0108BC23, 7, EU_STORE_BUFFER, 8'(LS_DOUBLEWORD), 5'b10100, IMM_TYPE_S, 2'b00, 0},
    '{"bltu", 32'h01396463, 7, EU_BRANCH_UNIT, 8'(BLTU), 5'b10100, IMM_TYPE_B, 2'b00, 0},
    '{"auipc", 32'h12345A17, 4, EU_INT_ALU, 8'(ALU_ADD), 5'b01011, IMM_TYPE_U, 2'b00, 0},
    '{"jal", 32'h010000EF, 4, EU_INT_ALU, 8'(ALU_ADD), 5'b01011, IMM_TYPE_J, 2'b01, 0},
    '{"jalr", 32'h000280E7, 6, EU_INT_ALU, 8'(ALU_ADD), 5'b10011, IMM_TYPE_I, 2'b01, 0},
    '{"lui", 32'hABCDE3B7, 4, EU_NONE, 8'd0, 5'b00001, IMM_TYPE_U, 2'b10, 0},
    // System
    '{"nop", 32'h00000013, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b11, 0},
    '{"fence", 32'h0FF0000F, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b11, 0},
    '{"ecall", 32'h00000073, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b11, 0},
    '{"ebreak", 32'h00100073, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b11, 3},
    '{"fencei", 32'h0000100F, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b11, 0},
    '{"csrrw", 32'h340312F3, 6, EU_OPERANDS_ONLY, 8'd0, 5'b10001, IMM_TYPE_I, 2'b01, 0},
    '{"csrrsi", 32'h3002E473, 6, EU_NONE, 8'd0, 5'b00001, IMM_TYPE_RS1, 2'b11, 0},
    // Illegal words
    '{"zero", 32'h00000000, 0, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b00, 2},
    '{"unkop", 32'h0000007B, 7, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b00, 2},
    '{"slli_b", 32'h04011093, 7, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b00, 2},
    '{"add_b", 32'h042081B3, 7, EU_NONE, 8'd0, 5'b00000, IMM_TYPE_I, 2'b00, 2}
};

// ==== tb_issue_decoder.sv ====
/*
 * Issue decoder testbench
 * Strobes each table entry into the decoder and checks the registered
 * results one cycle later, with idle gaps between some entries
 */
`default_nettype none

module tb_issue_decoder;
    timeunit 1ns;
    timeprecision 100ps;
    import issue_pkg::*;

    typedef struct {
        string               name;
        logic [ILEN-1:0]     word;
        logic [2:0]          rnd;
        issue_eu_e           eu;
        logic [EU_CTL_W-1:0] ctl;
        logic [4:0]          ops;
        imm_format_e         fmt;
        logic [1:0]          flags;
        logic [3:0]          xc;
    } vec_t;

    `include "tb_issue_vectors.svh"

    logic                clk_i;
    logic                rst_n_i;
    logic                instr_valid_i;
    instr_t              instr_i;
    logic                dec_valid_o;
    logic                dec_except_raised_o;
    except_code_e        dec_except_code_o;
    logic                dec_res_ready_o;
    logic                dec_stall_possible_o;
    issue_eu_e           dec_eu_o;
    logic [EU_CTL_W-1:0] dec_eu_ctl_o;
    logic                dec_rs1_req_o;
    logic                dec_rs1_is_pc_o;
    logic                dec_rs2_req_o;
    logic                dec_rs2_is_imm_o;
    imm_format_e         dec_imm_format_o;
    logic                dec_regstat_upd_o;

    logic [15:0] lfsr_state = 16'd52;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          entry_errors = 0;

    issue_decoder_top #(
        .ZIFENCEI_EN (1'b1),
        .ZICSR_EN    (1'b1)
    ) issue_decoder_top_inst (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .instr_valid_i        (instr_valid_i),
        .instr_i              (instr_i),
        .dec_valid_o          (dec_valid_o),
        .dec_except_raised_o  (dec_except_raised_o),
        .dec_except_code_o    (dec_except_code_o),
        .dec_res_ready_o      (dec_res_ready_o),
        .dec_stall_possible_o (dec_stall_possible_o),
        .dec_eu_o             (dec_eu_o),
        .dec_eu_ctl_o         (dec_eu_ctl_o),
        .dec_rs1_req_o        (dec_rs1_req_o),
        .dec_rs1_is_pc_o      (dec_rs1_is_pc_o),
        .dec_rs2_req_o        (dec_rs2_req_o),
        .dec_rs2_is_imm_o     (dec_rs2_is_imm_o),
        .dec_imm_format_o     (dec_imm_format_o),
        .dec_regstat_upd_o    (dec_regstat_upd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------
    // Random register fields
    // ------------------------------
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [4:0] take_field();
        logic [4:0] f;
        f = '0;
        for (int b = 0; b < 5; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            f = {f[3:0], lfsr_state[0]};
        end
        return f;
    endfunction

    function automatic logic [ILEN-1:0] build_word(input vec_t v);
        logic [ILEN-1:0] w;
        w = v.word;
        if (v.rnd[2]) begin
            w[11:7] = take_field();
        end
        if (v.rnd[1]) begin
            w[19:15] = take_field();
        end
        if (v.rnd[0]) begin
            w[24:20] = take_field();
        end
        return w;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %b got %b", $time, sig, exp, act);
            entry_errors++;
        end
    endtask

    task automatic check_vec(input string sig, input logic [EU_CTL_W-1:0] exp,
                             input logic [EU_CTL_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %0h got %0h", $time, sig, exp, act);
            entry_errors++;
        end
    endtask

    task automatic check_eu(input string sig, input issue_eu_e exp, input issue_eu_e act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %s got %s", $time, sig, exp.name(), act.name());
            entry_errors++;
        end
    endtask

    task automatic check_fmt(input string sig, input imm_format_e exp, input imm_format_e act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %s got %s", $time, sig, exp.name(), act.name());
            entry_errors++;
        end
    endtask

    task automatic check_code(input string sig, input except_code_e exp,
                              input except_code_e act);
        if (act !== exp) begin
            $display("FAIL at %0t: %s expected %s got %s", $time, sig, exp.name(), act.name());
            entry_errors++;
        end
    endtask

    task automatic close_test(input string name, input logic [ILEN-1:0] w);
        tests_run++;
        if (entry_errors != 0) begin
            tests_failed++;
        end
        $display("test %-7s instr %08h : %s", name, w, (entry_errors == 0) ? "ok" : "mismatch");
        entry_errors = 0;
    endtask

    // Data outputs of one table entry
    task automatic check_results(input vec_t v);
        check_bit("dec_except_raised_o", v.xc != 4'd0, dec_except_raised_o);
        if (v.xc != 4'd0) begin
            check_code("dec_except_code_o", except_code_e'(v.xc), dec_except_code_o);
        end
        check_bit("dec_res_ready_o", v.flags[1], dec_res_ready_o);
        check_bit("dec_stall_possible_o", v.flags[0], dec_stall_possible_o);
        check_eu("dec_eu_o", v.eu, dec_eu_o);
        check_vec("dec_eu_ctl_o", v.ctl, dec_eu_ctl_o);
        check_bit("dec_rs1_req_o", v.ops[4], dec_rs1_req_o);
        check_bit("dec_rs1_is_pc_o", v.ops[3], dec_rs1_is_pc_o);
        check_bit("dec_rs2_req_o", v.ops[2], dec_rs2_req_o);
        check_bit("dec_rs2_is_imm_o", v.ops[1], dec_rs2_is_imm_o);
        check_bit("dec_regstat_upd_o", v.ops[0], dec_regstat_upd_o);
        check_fmt("dec_imm_format_o", v.fmt, dec_imm_format_o);
    endtask

    task automatic check_entry(input vec_t v, input logic [ILEN-1:0] w);
        check_bit("dec_valid_o", 1'b1, dec_valid_o);
        check_results(v);
        close_test(v.name, w);
    endtask

    // Idle cycle with the last result still held
    task automatic check_hold(input vec_t v);
        check_bit("dec_valid_o", 1'b0, dec_valid_o);
        check_results(v);
        close_test("idle", instr_i);
    endtask

    // Reset values of every output
    task automatic check_reset();
        check_bit("dec_valid_o", 1'b0, dec_valid_o);
        check_bit("dec_except_raised_o", 1'b0, dec_except_raised_o);
        check_code("dec_except_code_o", E_ILLEGAL_INSTRUCTION, dec_except_code_o);
        check_bit("dec_res_ready_o", 1'b0, dec_res_ready_o);
        check_bit("dec_stall_possible_o", 1'b0, dec_stall_possible_o);
        check_eu("dec_eu_o", EU_NONE, dec_eu_o);
        check_vec("dec_eu_ctl_o", '0, dec_eu_ctl_o);
        check_bit("dec_rs1_req_o", 1'b0, dec_rs1_req_o);
        check_bit("dec_rs1_is_pc_o", 1'b0, dec_rs1_is_pc_o);
        check_bit("dec_rs2_req_o", 1'b0, dec_rs2_req_o);
        check_bit("dec_rs2_is_imm_o", 1'b0, dec_rs2_is_imm_o);
        check_bit("dec_regstat_upd_o", 1'b0, dec_regstat_upd_o);
        check_fmt("dec_imm_format_o", IMM_TYPE_I, dec_imm_format_o);
        close_test("reset", instr_i);
    endtask

    // ------------------------------
    // Stimulus loop
    // ------------------------------
    initial begin
        logic [ILEN-1:0] cur_word;
        logic [ILEN-1:0] next_word;
        logic            gap;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        #2;
        check_reset();
        cur_word      = build_word(vectors[0]);
        next_word     = cur_word;
        instr_valid_i = 1'b1;
        instr_i       = cur_word;
        for (int i = 0; i < NUM_VEC; i++) begin
            @(posedge clk_i);
            #2;
            // Every fourth entry is followed by an idle cycle
            gap = (i % 4 == 3) || (i == NUM_VEC - 1);
            if (!gap) begin
                next_word     = build_word(vectors[i + 1]);
                instr_valid_i = 1'b1;
                instr_i       = next_word;
            end else begin
                instr_valid_i = 1'b0;
                instr_i       = '0;
            end
            check_entry(vectors[i], cur_word);
            if (gap && i + 1 < NUM_VEC) begin
                @(posedge clk_i);
                #2;
                next_word     = build_word(vectors[i + 1]);
                instr_valid_i = 1'b1;
                instr_i       = next_word;
                // Sampled mid-cycle so a result that shows up early is caught
                #10;
                check_hold(vectors[i]);
            end
            cur_word = next_word;
        end
        @(posedge clk_i);
        #2;
        check_hold(vectors[NUM_VEC - 1]);
        $display("Tests run: %0d, tests failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((NUM_VEC + 20) * 40 * 2);
        $display("Watchdog expired before the test loop completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== issue_decoder_top.sv ====
/*
 * Issue-stage decoder, top level
 * Opcode classifier and full-match decoder in parallel, joined by
 * the registered merge stage
 */
`default_nettype none

module issue_decoder_top #(
    parameter bit ZIFENCEI_EN = 1'b1,
    parameter bit ZICSR_EN    = 1'b1
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            instr_valid_i,
    input  issue_pkg::instr_t               instr_i,
    output logic                            dec_valid_o,
    output logic                            dec_except_raised_o,
    output issue_pkg::except_code_e         dec_except_code_o,
    output logic                            dec_res_ready_o,
    output logic                            dec_stall_possible_o,
    output issue_pkg::issue_eu_e            dec_eu_o,
    output logic [issue_pkg::EU_CTL_W-1:0]  dec_eu_ctl_o,
    output logic                            dec_rs1_req_o,
    output logic                            dec_rs1_is_pc_o,
    output logic                            dec_rs2_req_o,
    output logic                            dec_rs2_is_imm_o,
    output issue_pkg::imm_format_e          dec_imm_format_o,
    output logic                            dec_regstat_upd_o
);

    issue_operand_if operand_if ();
    issue_exec_if    exec_if ();

    issue_opcode_classify issue_opcode_classify_inst (
        .instr_i (instr_i),
        .op      (operand_if)
    );

    issue_funct_decode #(
        .ZIFENCEI_EN (ZIFENCEI_EN),
        .ZICSR_EN    (ZICSR_EN)
    ) issue_funct_decode_inst (
        .instr_i (instr_i),
        .ex      (exec_if)
    );

    issue_decode_merge issue_decode_merge_inst (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .instr_valid_i        (instr_valid_i),
        .op                   (operand_if),
        .ex                   (exec_if),
        .dec_valid_o          (dec_valid_o),
        .dec_except_raised_o  (dec_except_raised_o),
        .dec_except_code_o    (dec_except_code_o),
        .dec_res_ready_o      (dec_res_ready_o),
        .dec_stall_possible_o (dec_stall_possible_o),
        .dec_eu_o             (dec_eu_o),
        .dec_eu_ctl_o         (dec_eu_ctl_o),
        .dec_rs1_req_o        (dec_rs1_req_o),
        .dec_rs1_is_pc_o      (dec_rs1_is_pc_o),
        .dec_rs2_req_o        (dec_rs2_req_o),
        .dec_rs2_is_imm_o     (dec_rs2_is_imm_o),
        .dec_imm_format_o     (dec_imm_format_o),
        .dec_regstat_upd_o    (dec_regstat_upd_o)
    );

endmodule

`default_nettype wire

// ==== issue_decode_merge.sv ====
/*
 * Merge stage
 * Combines operand controls and unit assignment, applies the
 * exception and override rules, registers the result on a strobe
 */
`default_nettype none

module issue_decode_merge (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            instr_valid_i,
    issue_operand_if.sink                   op,
    issue_exec_if.sink                      ex,
    output logic                            dec_valid_o,
    output logic                            dec_except_raised_o,
    output issue_pkg::except_code_e         dec_except_code_o,
    output logic                            dec_res_ready_o,
    output logic                            dec_stall_possible_o,
    output issue_pkg::issue_eu_e            dec_eu_o,
    output logic [issue_pkg::EU_CTL_W-1:0]  dec_eu_ctl_o,
    output logic                            dec_rs1_req_o,
    output logic                            dec_rs1_is_pc_o,
    output logic                            dec_rs2_req_o,
    output logic                            dec_rs2_is_imm_o,
    output issue_pkg::imm_format_e          dec_imm_format_o,
    output logic                            dec_regstat_upd_o
);
    import issue_pkg::*;

    logic illegal;
    logic no_operands;
    logic res_ready;
    logic stall_possible;

    assign illegal     = (ex.kind == KIND_ILLEGAL);
    // Kinds that never read the register file
    assign no_operands = ex.kind inside {KIND_ILLEGAL, KIND_NOP, KIND_FENCE, KIND_ECALL,
                                         KIND_EBREAK, KIND_FENCE_I};
    assign res_ready   = ex.kind inside {KIND_NOP, KIND_LUI, KIND_FENCE, KIND_ECALL,
                                         KIND_EBREAK, KIND_FENCE_I, KIND_CSR_IMM};
    assign stall_possible = ex.kind inside {KIND_NOP, KIND_JUMP, KIND_FENCE, KIND_ECALL,
                                            KIND_EBREAK, KIND_FENCE_I, KIND_CSR_REG,
                                            KIND_CSR_IMM};

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o          <= 1'b0;
            dec_except_raised_o  <= 1'b0;
            dec_except_code_o    <= E_ILLEGAL_INSTRUCTION;
            dec_res_ready_o      <= 1'b0;
            dec_stall_possible_o <= 1'b0;
            dec_eu_o             <= EU_NONE;
            dec_eu_ctl_o         <= '0;
            dec_rs1_req_o        <= 1'b0;
            dec_rs1_is_pc_o      <= 1'b0;
            dec_rs2_req_o        <= 1'b0;
            dec_rs2_is_imm_o     <= 1'b0;
            dec_imm_format_o     <= IMM_TYPE_I;
            dec_regstat_upd_o    <= 1'b0;
        end else begin
            dec_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                dec_except_raised_o  <= illegal || (ex.kind == KIND_EBREAK);
                dec_except_code_o    <= illegal ? E_ILLEGAL_INSTRUCTION : E_BREAKPOINT;
                dec_res_ready_o      <= res_ready;
                dec_stall_possible_o <= stall_possible;
                dec_eu_o             <= illegal ? EU_NONE : ex.eu;
                dec_eu_ctl_o         <= illegal ? '0 : ex.eu_ctl;
                dec_rs1_req_o        <= op.rs1_req && !no_operands;
                dec_rs1_is_pc_o      <= op.rs1_is_pc && !no_operands;
                dec_rs2_req_o        <= op.rs2_req && !no_operands;
                dec_rs2_is_imm_o     <= op.rs2_is_imm && !no_operands;
                dec_imm_format_o     <= no_operands ? IMM_TYPE_I : op.imm_format;
                dec_regstat_upd_o    <= op.regstat_upd && !no_operands;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issue_funct_decode.sv ====
/*
 * Full-match decoder
 * Checks every field of the encoding and gives the instruction kind,
 * its execution unit and that unit's control code
 */
`default_nettype none

module issue_funct_decode #(
    parameter bit ZIFENCEI_EN = 1'b1,
    parameter bit ZICSR_EN    = 1'b1
) (
    input  issue_pkg::instr_t instr_i,
    issue_exec_if.source      ex
);
    import issue_pkg::*;

    logic       alu_hit;
    alu_op_e    alu_op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       sh6_lo;
    logic       sh6_ar;
    logic       sys_zero;

    assign f3     = instr_i.r.funct3;
    assign f7     = instr_i.r.funct7;
    // Upper shift bits of a 64-bit shift, SRAI carries 010000
    assign sh6_lo = (instr_i.raw[31:26] == 6'b000000);
    assign sh6_ar = (instr_i.raw[31:26] == 6'b010000);
    // rd and rs1 both x0
    assign sys_zero = (instr_i.r.rs1 == 5'd0) && (instr_i.r.rd == 5'd0);

    always_comb begin
        alu_hit   = 1'b0;
        alu_op    = ALU_ADD;
        ex.kind   = KIND_ILLEGAL;
        ex.eu     = EU_NONE;
        ex.eu_ctl = '0;

        case (instr_i.r.opcode)
            OPCODE_LUI:   ex.kind = KIND_LUI;
            OPCODE_AUIPC: alu_hit = 1'b1;
            OPCODE_JAL: begin
                ex.kind = KIND_JUMP;
                alu_hit = 1'b1;
            end
            OPCODE_JALR: begin
                if (f3 == 3'b000) begin
                    ex.kind = KIND_JUMP;
                    alu_hit = 1'b1;
                end
            end
            OPCODE_BRANCH: begin
                ex.kind = KIND_OTHER;
                ex.eu   = EU_BRANCH_UNIT;
                case (f3)
                    3'b000:  ex.eu_ctl = EU_CTL_W'(BEQ);
                    3'b001:  ex.eu_ctl = EU_CTL_W'(BNE);
                    3'b100:  ex.eu_ctl = EU_CTL_W'(BLT);
                    3'b101:  ex.eu_ctl = EU_CTL_W'(BGE);
                    3'b110:  ex.eu_ctl = EU_CTL_W'(BLTU);
                    3'b111:  ex.eu_ctl = EU_CTL_W'(BGEU);
                    default: begin
                        ex.kind = KIND_ILLEGAL;
                        ex.eu   = EU_NONE;
                    end
                endcase
            end
            // Width codes run in funct3 order, 111 is reserved
            OPCODE_LOAD: begin
                if (f3 != 3'b111) begin
                    ex.kind   = KIND_OTHER;
                    ex.eu     = EU_LOAD_BUFFER;
                    ex.eu_ctl = EU_CTL_W'(ls_width_e'(f3));
                end
            end
            OPCODE_STORE: begin
                if (!f3[2]) begin
                    ex.kind   = KIND_OTHER;
                    ex.eu     = EU_STORE_BUFFER;
                    ex.eu_ctl = EU_CTL_W'(ls_width_e'(f3));
                end
            end
            OPCODE_OP_IMM: begin
                case (f3)
                    3'b000: begin
                        if (instr_i.r.rs1 == 5'd0 && instr_i.raw[31:20] == 12'd0) begin
                            ex.kind = KIND_NOP;
                        end else begin
                            alu_hit = 1'b1;
                        end
                    end
                    3'b010: {alu_hit, alu_op} = {1'b1, ALU_SLT};
                    3'b011: {alu_hit, alu_op} = {1'b1, ALU_SLTU};
                    3'b100: {alu_hit, alu_op} = {1'b1, ALU_XOR};
                    3'b110: {alu_hit, alu_op} = {1'b1, ALU_OR};
                    3'b111: {alu_hit, alu_op} = {1'b1, ALU_AND};
                    3'b001: {alu_hit, alu_op} = {sh6_lo, ALU_SLL};
                    default: begin
                        alu_hit = sh6_lo || sh6_ar;
                        alu_op  = sh6_ar ? ALU_SRA : ALU_SRL;
                    end
                endcase
            end
            OPCODE_OP_IMM_32: begin
                case (f3)
                    3'b000: {alu_hit, alu_op} = {1'b1, ALU_ADDW};
                    3'b001: {alu_hit, alu_op} = {(f7 == 7'b0000000), ALU_SLLW};
                    3'b101: begin
                        alu_hit = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                        alu_op  = f7[5] ? ALU_SRAW : ALU_SRLW;
                    end
                    default: ;
                endcase
            end
            OPCODE_OP: begin
                case ({f7, f3})
                    10'b0000000_000: {alu_hit, alu_op} = {1'b1, ALU_ADD};
                    10'b0100000_000: {alu_hit, alu_op} = {1'b1, ALU_SUB};
                    10'b0000000_001: {alu_hit, alu_op} = {1'b1, ALU_SLL};
                    10'b0000000_010: {alu_hit, alu_op} = {1'b1, ALU_SLT};
                    10'b0000000_011: {alu_hit, alu_op} = {1'b1, ALU_SLTU};
                    10'b0000000_100: {alu_hit, alu_op} = {1'b1, ALU_XOR};
                    10'b0000000_101: {alu_hit, alu_op} = {1'b1, ALU_SRL};
                    10'b0100000_101: {alu_hit, alu_op} = {1'b1, ALU_SRA};
                    10'b0000000_110: {alu_hit, alu_op} = {1'b1, ALU_OR};
                    10'b0000000_111: {alu_hit, alu_op} = {1'b1, ALU_AND};
                    default: ;
                endcase
            end
            OPCODE_OP_32: begin
                case ({f7, f3})
                    10'b0000000_000: {alu_hit, alu_op} = {1'b1, ALU_ADDW};
                    10'b0100000_000: {alu_hit, alu_op} = {1'b1, ALU_SUBW};
                    10'b0000000_001: {alu_hit, alu_op} = {1'b1, ALU_SLLW};
                    10'b0000000_101: {alu_hit, alu_op} = {1'b1, ALU_SRLW};
                    10'b0100000_101: {alu_hit, alu_op} = {1'b1, ALU_SRAW};
                    default: ;
                endcase
            end
            OPCODE_MISC_MEM: begin
                // FENCE keeps pred/succ free, FENCE.I needs a zero immediate
                if (f3 == 3'b000 && sys_zero && instr_i.raw[30:28] == 3'b000) begin
                    ex.kind = KIND_FENCE;
                end else if (ZIFENCEI_EN && f3 == 3'b001 && sys_zero &&
                             instr_i.raw[31:20] == 12'd0) begin
                    ex.kind = KIND_FENCE_I;
                end
            end
            OPCODE_SYSTEM: begin
                if (f3 == 3'b000) begin
                    if (sys_zero && instr_i.raw[31:20] == 12'd0) begin
                        ex.kind = KIND_ECALL;
                    end else if (sys_zero && instr_i.raw[31:20] == 12'd1) begin
                        ex.kind = KIND_EBREAK;
                    end
                end else if (ZICSR_EN && f3 != 3'b100) begin
                    ex.kind = f3[2] ? KIND_CSR_IMM : KIND_CSR_REG;
                    ex.eu   = f3[2] ? EU_NONE : EU_OPERANDS_ONLY;
                end
            end
            default: ;
        endcase

        if (alu_hit) begin
            ex.eu     = EU_INT_ALU;
            ex.eu_ctl = EU_CTL_W'(alu_op);
            if (ex.kind == KIND_ILLEGAL) begin
                ex.kind = KIND_OTHER;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issue_opcode_classify.sv ====
/*
 * Opcode classifier
 * Operand-fetch requests, immediate format and register-status
 * update, taken from the major opcode alone
 */
`default_nettype none

module issue_opcode_classify (
    input  issue_pkg::instr_t instr_i,
    issue_operand_if.source   op
);
    import issue_pkg::*;

    always_comb begin
        op.rs1_req     = 1'b0;
        op.rs1_is_pc   = 1'b0;
        op.rs2_req     = 1'b0;
        op.rs2_is_imm  = 1'b0;
        op.imm_format  = IMM_TYPE_I;
        op.regstat_upd = 1'b0;

        case (instr_i.r.opcode)
            OPCODE_LOAD: begin
                op.rs1_req     = 1'b1;
                op.regstat_upd = 1'b1;
            end
            OPCODE_STORE: begin
                op.rs1_req    = 1'b1;
                op.rs2_req    = 1'b1;
                op.imm_format = IMM_TYPE_S;
            end
            OPCODE_BRANCH: begin
                op.rs1_req    = 1'b1;
                op.rs2_req    = 1'b1;
                op.imm_format = IMM_TYPE_B;
            end
            OPCODE_OP, OPCODE_OP_32: begin
                op.rs1_req     = 1'b1;
                op.rs2_req     = 1'b1;
                op.regstat_upd = 1'b1;
            end
            OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: begin
                op.rs1_req     = 1'b1;
                op.rs2_is_imm  = 1'b1;
                op.regstat_upd = 1'b1;
            end
            // PC plus immediate
            OPCODE_AUIPC, OPCODE_JAL: begin
                op.rs1_is_pc   = 1'b1;
                op.rs2_is_imm  = 1'b1;
                op.imm_format  = (instr_i.r.opcode == OPCODE_JAL) ? IMM_TYPE_J : IMM_TYPE_U;
                op.regstat_upd = 1'b1;
            end
            OPCODE_LUI: begin
                op.imm_format  = IMM_TYPE_U;
                op.regstat_upd = 1'b1;
            end
            OPCODE_SYSTEM: begin
                // CSR forms only, funct3[2] picks the uimm source
                if (instr_i.r.funct3 != 3'b000) begin
                    op.regstat_upd = 1'b1;
                    if (instr_i.r.funct3[2]) begin
                        op.imm_format = IMM_TYPE_RS1;
                    end else begin
                        op.rs1_req = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== issue_if.sv ====
/*
 * Issue decoder internal buses
 * Operand controls from the opcode classifier and unit assignment
 * from the full-match decoder, both read by the merge stage
 */
`default_nettype none

interface issue_operand_if;
    import issue_pkg::*;

    logic        rs1_req;
    logic        rs1_is_pc;
    logic        rs2_req;
    logic        rs2_is_imm;
    imm_format_e imm_format;
    logic        regstat_upd;

    modport source (output rs1_req, rs1_is_pc, rs2_req, rs2_is_imm, imm_format, regstat_upd);
    modport sink   (input  rs1_req, rs1_is_pc, rs2_req, rs2_is_imm, imm_format, regstat_upd);
endinterface

interface issue_exec_if;
    import issue_pkg::*;

    insn_kind_e          kind;
    issue_eu_e           eu;
    logic [EU_CTL_W-1:0] eu_ctl;

    modport source (output kind, eu, eu_ctl);
    modport sink   (input  kind, eu, eu_ctl);
endinterface

`default_nettype wire

// ==== issue_pkg.sv ====
/*
 * Issue decoder package
 * Instruction layout, major opcodes, execution unit codes and the
 * control codes produced by the RV64I issue-stage decoder
 */
`default_nettype none

package issue_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int unsigned ILEN     = 32;
    localparam int unsigned EU_CTL_W = 8;

    // ------------------------------
    // Instruction encoding
    // ------------------------------
    // RV64I major opcodes
    typedef enum logic [6:0] {
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_OP_IMM_32 = 7'b0011011,
        OPCODE_OP        = 7'b0110011,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_LUI       = 7'b0110111,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_MISC_MEM  = 7'b0001111,
        OPCODE_SYSTEM    = 7'b1110011
    } opcode_e;

    // R-type view, the other formats are taken as slices of it
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef union packed {
        logic [ILEN-1:0] raw;
        instr_r_t        r;
    } instr_t;

    // ------------------------------
    // Decoder results
    // ------------------------------
    typedef enum logic [2:0] {
        EU_NONE,
        EU_INT_ALU,
        EU_BRANCH_UNIT,
        EU_LOAD_BUFFER,
        EU_STORE_BUFFER,
        EU_OPERANDS_ONLY
    } issue_eu_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDW, ALU_SUB, ALU_SUBW,
        ALU_SLL, ALU_SLLW, ALU_SRL, ALU_SRLW,
        ALU_SRA, ALU_SRAW, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        BEQ, BNE, BLT, BGE, BLTU, BGEU
    } branch_op_e;

    // Shared by the load and the store buffer
    typedef enum logic [2:0] {
        LS_BYTE, LS_HALFWORD, LS_WORD, LS_DOUBLEWORD,
        LS_BYTE_U, LS_HALFWORD_U, LS_WORD_U
    } ls_width_e;

    typedef enum logic [2:0] {
        IMM_TYPE_I, IMM_TYPE_S, IMM_TYPE_B, IMM_TYPE_U, IMM_TYPE_J, IMM_TYPE_RS1
    } imm_format_e;

    typedef enum logic [3:0] {
        E_ILLEGAL_INSTRUCTION = 4'd2,
        E_BREAKPOINT          = 4'd3
    } except_code_e;

    // Instruction classes that steer the merge stage
    typedef enum logic [3:0] {
        KIND_ILLEGAL, KIND_NOP, KIND_LUI, KIND_JUMP,
        KIND_FENCE, KIND_ECALL, KIND_EBREAK, KIND_FENCE_I,
        KIND_CSR_REG, KIND_CSR_IMM, KIND_OTHER
    } insn_kind_e;

endpackage

`default_nettype wire
